// ==== hw/emif_pkg.sv ====
/*
 * EMIF write path shared types
 * Address, data, port, offset widths and the drain FSM states
 */
`default_nettype none

package emif_pkg;

    // ==============================
    // Bus widths
    // ==============================
    // Word address on the EMIF bus
    typedef logic [22:0] emif_addr_t;
    // One EMIF data word
    typedef logic [17:0] emif_data_t;

    // ==============================
    // Slot and port fields
    // ==============================
    // Target port inside the slot, {addr[20:19], addr[14]}
    typedef logic [2:0] port_num_t;
    // Card slot, compared with addr[18:15]
    typedef logic [3:0] slot_num_t;
    // Word offset in a burst, wraps after 256 words
    typedef logic [7:0] port_ofs_t;

    // Drain FSM
    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_READ,
        DRAIN_WAIT
    } drain_state_t;

endpackage

`default_nettype wire

// ==== hw/emif_bus_capture.sv ====
/*
 * EMIF bus capture
 * Registers the pins and turns chip-select and write-strobe edges into strobes
 */
`timescale 1ns/100ps
`default_nettype none

module emif_bus_capture (
    input  wire                     clk_emif,
    input  wire                     rst_emif,
    input  wire                     emif_cs_n,
    input  wire                     emif_we_n,
    input  wire emif_pkg::emif_addr_t emif_addr,
    input  wire emif_pkg::emif_data_t emif_data,
    output logic                    cs_fall,
    output logic                    wr_en,
    output logic                    wr_eop,
    output emif_pkg::emif_addr_t    wr_addr,
    output emif_pkg::emif_data_t    wr_data
);

    import emif_pkg::*;

    // Input register stage
    logic       cs_n_q;
    logic       we_n_q;
    emif_addr_t addr_q;
    emif_data_t data_q;

    // Previous levels for edge detection
    logic       cs_n_d;
    logic       we_n_d;

    // ==============================
    // Pin registers
    // ==============================
    // Idle bus is high on both strobes
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            cs_n_q <= 1'b1;
            we_n_q <= 1'b1;
            cs_n_d <= 1'b1;
            we_n_d <= 1'b1;
        end else begin
            cs_n_q <= emif_cs_n;
            we_n_q <= emif_we_n;
            cs_n_d <= cs_n_q;
            we_n_d <= we_n_q;
        end
    end

    // Address and data follow the strobes stage for stage
    always_ff @(posedge clk_emif) begin
        addr_q  <= emif_addr;
        data_q  <= emif_data;
        wr_addr <= addr_q;
        wr_data <= data_q;
    end

    // ==============================
    // Edge strobes
    // ==============================
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            cs_fall <= 1'b0;
            wr_en   <= 1'b0;
            wr_eop  <= 1'b0;
        end else begin
            // First registered cycle with chip select low
            cs_fall <= cs_n_d & ~cs_n_q;
            // we_n fall, only inside a burst
            wr_en   <= we_n_d & ~we_n_q & ~cs_n_q;
            // Chip select rise closes the packet
            wr_eop  <= ~cs_n_d & cs_n_q;
        end
    end

endmodule

`default_nettype wire

// ==== hw/type2_wr_decode.sv ====
/*
 * Type-2 write decoder
 * Selects bursts addressed to this slot and extracts the target port
 */
`timescale 1ns/100ps
`default_nettype none

module type2_wr_decode #(
    parameter emif_pkg::slot_num_t SLOT_NUM = 4'd0
) (
    input  wire                     clk_emif,
    input  wire                     rst_emif,
    input  wire                     cs_fall,
    input  wire                     wr_en,
    input  wire emif_pkg::emif_addr_t wr_addr,
    input  wire emif_pkg::emif_data_t wr_data,
    input  wire                     wr_eop,
    output logic                    type2_wr_sel,
    output logic                    type2_wr_en,
    output emif_pkg::port_num_t     type2_wr_port,
    output emif_pkg::emif_data_t    type2_wr_data
);

    import emif_pkg::*;

    logic      cs_fall_d1;
    slot_num_t addr_slot;
    logic      addr_match;

    // ==============================
    // Address match
    // ==============================
    assign addr_slot = wr_addr[18:15];

    // Type 2, this slot, addr[13] clear
    assign addr_match = (wr_addr[22:21] == 2'b00) && (addr_slot == SLOT_NUM) &&
                        !wr_addr[13];

    // Select level, end of packet wins
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            cs_fall_d1   <= 1'b0;
            type2_wr_sel <= 1'b0;
        end else begin
            cs_fall_d1 <= cs_fall;
            if (wr_eop) begin
                type2_wr_sel <= 1'b0;
            end else if (cs_fall_d1) begin
                type2_wr_sel <= addr_match;
            end
        end
    end

    // Port field held for the whole burst
    always_ff @(posedge clk_emif) begin
        if (cs_fall) begin
            type2_wr_port <= {wr_addr[20:19], wr_addr[14]};
        end
    end

    // ==============================
    // Write retiming
    // ==============================
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            type2_wr_en <= 1'b0;
        end else begin
            type2_wr_en <= wr_en;
        end
    end

    // Data lines up with type2_wr_en
    always_ff @(posedge clk_emif) begin
        type2_wr_data <= wr_data;
    end

endmodule

`default_nettype wire

// ==== hw/port_wr_buffer.sv ====
/*
 * Port write buffer
 * FIFO of selected words with first-of-burst marker and sticky overflow
 */
`timescale 1ns/100ps
`default_nettype none

module port_wr_buffer #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                     clk_emif,
    input  wire                     rst_emif,
    input  wire                     type2_wr_sel,
    input  wire                     type2_wr_en,
    input  wire emif_pkg::port_num_t  type2_wr_port,
    input  wire emif_pkg::emif_data_t type2_wr_data,
    input  wire                     buf_pop,
    output logic                    buf_empty,
    output emif_pkg::port_num_t     buf_port,
    output emif_pkg::emif_data_t    buf_data,
    output logic                    buf_first,
    output logic                    wr_overflow
);

    import emif_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam bit [PTR_W:0] FULL_CNT = FIFO_DEPTH[PTR_W:0];

    // Entry storage
    port_num_t  port_mem  [FIFO_DEPTH];
    emif_data_t data_mem  [FIFO_DEPTH];
    logic       first_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             burst_started;
    logic             push;
    logic             push_ok;
    logic             full;

    // ==============================
    // Push qualification
    // ==============================
    assign push      = type2_wr_en & type2_wr_sel;
    assign full      = (count == FULL_CNT);
    assign push_ok   = push & ~full;
    assign buf_empty = (count == '0);

    // Pointers, count, burst tracking, overflow
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            burst_started <= 1'b0;
            wr_overflow   <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (buf_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, buf_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Cleared between bursts, first stored word marks the start
            if (!type2_wr_sel) begin
                burst_started <= 1'b0;
            end else if (push_ok) begin
                burst_started <= 1'b1;
            end
            // Dropped word, held until reset
            if (push && full) begin
                wr_overflow <= 1'b1;
            end
        end
    end

    // ==============================
    // Storage and read port
    // ==============================
    always_ff @(posedge clk_emif) begin
        if (push_ok) begin
            port_mem[wr_ptr]  <= type2_wr_port;
            data_mem[wr_ptr]  <= type2_wr_data;
            first_mem[wr_ptr] <= ~burst_started;
        end
        // Head word valid the cycle after the pop
        if (buf_pop) begin
            buf_port  <= port_mem[rd_ptr];
            buf_data  <= data_mem[rd_ptr];
            buf_first <= first_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/port_wr_drain.sv ====
/*
 * Port write drain
 * Paced FIFO reader producing port writes with per-burst word offsets
 */
`timescale 1ns/100ps
`default_nettype none

module port_wr_drain #(
    parameter int DRAIN_GAP = 3
) (
    input  wire                     clk_emif,
    input  wire                     rst_emif,
    input  wire                     buf_empty,
    input  wire emif_pkg::port_num_t  buf_port,
    input  wire emif_pkg::emif_data_t buf_data,
    input  wire                     buf_first,
    output logic                    buf_pop,
    output logic                    port_wr_en,
    output emif_pkg::port_num_t     port_wr_port,
    output emif_pkg::port_ofs_t     port_wr_ofs,
    output emif_pkg::emif_data_t    port_wr_data
);

    import emif_pkg::*;

    // IDLE and READ already take two cycles of the gap
    localparam int GAP_W    = $clog2(DRAIN_GAP + 1);
    localparam int GAP_LAST = (DRAIN_GAP > 2) ? DRAIN_GAP - 3 : 0;

    drain_state_t     state;
    port_ofs_t        ofs_cnt;
    logic [GAP_W-1:0] gap_cnt;

    // ==============================
    // Outputs
    // ==============================
    assign buf_pop      = (state == DRAIN_IDLE) & ~buf_empty;
    assign port_wr_en   = (state == DRAIN_READ);
    assign port_wr_port = buf_port;
    assign port_wr_data = buf_data;
    // New burst restarts at offset 0
    assign port_wr_ofs  = buf_first ? '0 : ofs_cnt;

    // FSM and stored offset
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            state   <= DRAIN_IDLE;
            ofs_cnt <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                DRAIN_IDLE: begin
                    if (!buf_empty) begin
                        state <= DRAIN_READ;
                    end
                end
                DRAIN_READ: begin
                    ofs_cnt <= port_wr_ofs + 1'b1;
                    gap_cnt <= '0;
                    state   <= (DRAIN_GAP > 2) ? DRAIN_WAIT : DRAIN_IDLE;
                end
                DRAIN_WAIT: begin
                    if (gap_cnt == GAP_W'(GAP_LAST)) begin
                        state <= DRAIN_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= DRAIN_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/emif_wr_top.sv ====
/*
 * EMIF type-2 write path top level
 * Capture, decode, buffer and paced drain to the port memories
 */
`timescale 1ns/100ps
`default_nettype none

module emif_wr_top #(
    parameter emif_pkg::slot_num_t SLOT_NUM = 4'd0,
    parameter int FIFO_DEPTH = 8,
    parameter int DRAIN_GAP  = 3
) (
    input  wire                     clk_emif,
    input  wire                     rst_emif,
    input  wire                     emif_cs_n,
    input  wire                     emif_we_n,
    input  wire emif_pkg::emif_addr_t emif_addr,
    input  wire emif_pkg::emif_data_t emif_data,
    output logic                    port_wr_en,
    output emif_pkg::port_num_t     port_wr_port,
    output emif_pkg::port_ofs_t     port_wr_ofs,
    output emif_pkg::emif_data_t    port_wr_data,
    output logic                    wr_overflow
);

    import emif_pkg::*;

    // ==============================
    // Internal nets
    // ==============================
    // Capture to decoder
    logic       cs_fall;
    logic       wr_en;
    logic       wr_eop;
    emif_addr_t wr_addr;
    emif_data_t wr_data;

    // Decoder to buffer
    logic       type2_wr_sel;
    logic       type2_wr_en;
    port_num_t  type2_wr_port;
    emif_data_t type2_wr_data;

    // Buffer to drain
    logic       buf_empty;
    logic       buf_pop;
    port_num_t  buf_port;
    emif_data_t buf_data;
    logic       buf_first;

    emif_bus_capture u_capture (
        .clk_emif  (clk_emif),
        .rst_emif  (rst_emif),
        .emif_cs_n (emif_cs_n),
        .emif_we_n (emif_we_n),
        .emif_addr (emif_addr),
        .emif_data (emif_data),
        .cs_fall   (cs_fall),
        .wr_en     (wr_en),
        .wr_eop    (wr_eop),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    type2_wr_decode #(
        .SLOT_NUM (SLOT_NUM)
    ) u_decode (
        .clk_emif      (clk_emif),
        .rst_emif      (rst_emif),
        .cs_fall       (cs_fall),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_eop        (wr_eop),
        .type2_wr_sel  (type2_wr_sel),
        .type2_wr_en   (type2_wr_en),
        .type2_wr_port (type2_wr_port),
        .type2_wr_data (type2_wr_data)
    );

    port_wr_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .clk_emif      (clk_emif),
        .rst_emif      (rst_emif),
        .type2_wr_sel  (type2_wr_sel),
        .type2_wr_en   (type2_wr_en),
        .type2_wr_port (type2_wr_port),
        .type2_wr_data (type2_wr_data),
        .buf_pop       (buf_pop),
        .buf_empty     (buf_empty),
        .buf_port      (buf_port),
        .buf_data      (buf_data),
        .buf_first     (buf_first),
        .wr_overflow   (wr_overflow)
    );

    // Paced toward the slower port memory
    port_wr_drain #(
        .DRAIN_GAP (DRAIN_GAP)
    ) u_drain (
        .clk_emif     (clk_emif),
        .rst_emif     (rst_emif),
        .buf_empty    (buf_empty),
        .buf_port     (buf_port),
        .buf_data     (buf_data),
        .buf_first    (buf_first),
        .buf_pop      (buf_pop),
        .port_wr_en   (port_wr_en),
        .port_wr_port (port_wr_port),
        .port_wr_ofs  (port_wr_ofs),
        .port_wr_data (port_wr_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_emif_wr_top.sv ====
/*
 * Testbench for the EMIF type-2 write path
 * Drives write bursts and scoreboards the paced port writes
 */
`timescale 1ns/100ps
`default_nettype none

module tb_emif_wr_top;

    import emif_pkg::*;

    localparam slot_num_t SLOT_NUM   = 4'd5;
    localparam int        FIFO_DEPTH = 8;
    localparam int        DRAIN_GAP  = 3;
    // All burst words of the run
    localparam int TOTAL_WORDS     = 59;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 2 * DRAIN_GAP + 400;

    logic       clk_emif;
    logic       rst_emif;
    logic       emif_cs_n;
    logic       emif_we_n;
    emif_addr_t emif_addr;
    emif_data_t emif_data;
    logic       port_wr_en;
    port_num_t  port_wr_port;
    port_ofs_t  port_wr_ofs;
    emif_data_t port_wr_data;
    logic       wr_overflow;

    // Scoreboard of expected port writes
    port_num_t  exp_port [$];
    port_ofs_t  exp_ofs  [$];
    emif_data_t exp_data [$];

    integer    seed;
    int        value_errs;
    int        other_errs;
    int        cycle_cnt;
    int        last_wr_cycle;
    int        idle_cycles;
    bit        lossy;
    port_ofs_t lossy_ofs;
    port_ofs_t ofs_ref;

    emif_wr_top #(
        .SLOT_NUM   (SLOT_NUM),
        .FIFO_DEPTH (FIFO_DEPTH),
        .DRAIN_GAP  (DRAIN_GAP)
    ) u_emif_wr_top (
        .clk_emif     (clk_emif),
        .rst_emif     (rst_emif),
        .emif_cs_n    (emif_cs_n),
        .emif_we_n    (emif_we_n),
        .emif_addr    (emif_addr),
        .emif_data    (emif_data),
        .port_wr_en   (port_wr_en),
        .port_wr_port (port_wr_port),
        .port_wr_ofs  (port_wr_ofs),
        .port_wr_data (port_wr_data),
        .wr_overflow  (wr_overflow)
    );

    // 100 ns clock
    always #50 clk_emif = ~clk_emif;

    // ==============================
    // Bus driver
    // ==============================
    // Address fields from the type down to the word index
    function automatic emif_addr_t make_addr(input logic [1:0] kind, input slot_num_t slot,
                                             input port_num_t port, input logic b13);
        return {kind, port[2:1], slot, port[0], b13, 13'h01c4};
    endfunction

    task automatic write_burst(input emif_addr_t addr, input int n_words);
        bit         hit;
        port_num_t  port;
        emif_data_t word;
        int         i;
        // Type 2, our slot, bit 13 clear
        hit  = (addr[22:21] == 2'b00) && (addr[18:15] == SLOT_NUM) && !addr[13];
        port = {addr[20:19], addr[14]};
        @(negedge clk_emif);
        emif_cs_n = 1'b0;
        emif_addr = addr;
        // Strobe no earlier than 2 cycles after chip select
        repeat (2) @(negedge clk_emif);
        for (i = 0; i < n_words; i++) begin
            word      = emif_data_t'($random(seed));
            emif_we_n = 1'b0;
            emif_data = word;
            if (hit) begin
                exp_port.push_back(port);
                exp_ofs.push_back(port_ofs_t'(i));
                exp_data.push_back(word);
            end
            @(negedge clk_emif);
            emif_we_n = 1'b1;
            @(negedge clk_emif);
        end
        emif_cs_n = 1'b1;
        repeat (3) @(negedge clk_emif);
    endtask

    // Returns on a posedge once the drain has gone quiet
    task automatic wait_drain(input bit check_empty);
        repeat (16) @(posedge clk_emif);
        while (idle_cycles < 16) begin
            @(posedge clk_emif);
        end
        if (check_empty) begin
            assert (exp_data.size() == 0) else begin
                $display("Missing port writes, %0d still expected", exp_data.size());
                other_errs++;
            end
        end
    endtask

    function automatic void drop_head();
        void'(exp_port.pop_front());
        void'(exp_ofs.pop_front());
        void'(exp_data.pop_front());
    endfunction

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk_emif) begin
        cycle_cnt = cycle_cnt + 1;
        if (port_wr_en) begin
            // Drain pacing
            assert (cycle_cnt - last_wr_cycle >= DRAIN_GAP) else begin
                $display("Port writes only %0d cycles apart", cycle_cnt - last_wr_cycle);
                other_errs++;
            end
            last_wr_cycle = cycle_cnt;
            idle_cycles   = 0;
            // Skip words dropped by the full buffer
            if (lossy) begin
                while (exp_data.size() > 0 && exp_data[0] != port_wr_data) begin
                    drop_head();
                end
            end
            assert (exp_data.size() > 0) else begin
                $display("Unexpected port write of data %h", port_wr_data);
                other_errs++;
            end
            if (exp_data.size() > 0) begin
                ofs_ref = lossy ? lossy_ofs : exp_ofs[0];
                assert (port_wr_port == exp_port[0]) else begin
                    $display("ERR port_wr_port got %h expected %h", port_wr_port, exp_port[0]);
                    value_errs++;
                end
                assert (port_wr_ofs == ofs_ref) else begin
                    $display("ERR port_wr_ofs got %h expected %h", port_wr_ofs, ofs_ref);
                    value_errs++;
                end
                assert (port_wr_data == exp_data[0]) else begin
                    $display("ERR port_wr_data got %h expected %h", port_wr_data, exp_data[0]);
                    value_errs++;
                end
                lossy_ofs = lossy_ofs + 8'd1;
                drop_head();
            end
        end else begin
            idle_cycles = idle_cycles + 1;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        clk_emif      = 1'b0;
        rst_emif      = 1'b0;
        emif_cs_n     = 1'b1;
        emif_we_n     = 1'b1;
        emif_addr     = '0;
        emif_data     = '0;
        seed          = 32'h65a5_ee00;
        value_errs    = 0;
        other_errs    = 0;
        cycle_cnt     = 0;
        last_wr_cycle = -1000;
        idle_cycles   = 0;
        lossy         = 1'b0;
        lossy_ofs     = '0;
        repeat (2) @(negedge clk_emif);
        rst_emif = 1'b1;
        @(negedge clk_emif);
        assert (!port_wr_en && !wr_overflow) else begin
            $display("Outputs not idle after reset");
            other_errs++;
        end

        // Plain burst to port 6
        write_burst(make_addr(2'b00, 4'd5, 3'd6, 1'b0), 5);
        wait_drain(1'b1);

        // Wrong address type, then wrong slot
        write_burst(make_addr(2'b01, 4'd5, 3'd2, 1'b0), 4);
        write_burst(make_addr(2'b00, 4'd4, 3'd2, 1'b0), 4);
        wait_drain(1'b1);

        // Bit 13 set and then a good burst
        write_burst(make_addr(2'b00, 4'd5, 3'd7, 1'b1), 3);
        write_burst(make_addr(2'b00, 4'd5, 3'd7, 1'b0), 3);
        wait_drain(1'b1);

        // Offsets restart on back-to-back bursts
        write_burst(make_addr(2'b00, 4'd5, 3'd1, 1'b0), 4);
        write_burst(make_addr(2'b00, 4'd5, 3'd3, 1'b0), 4);
        wait_drain(1'b1);

        @(negedge clk_emif);
        assert (!wr_overflow) else begin
            $display("ERR wr_overflow got %h expected %h", wr_overflow, 1'b0);
            value_errs++;
        end

        // Overrun of the 8-entry buffer
        // One word in two cycles against one drained in three
        lossy     = 1'b1;
        lossy_ofs = '0;
        write_burst(make_addr(2'b00, 4'd5, 3'd4, 1'b0), 32);
        wait_drain(1'b0);
        lossy = 1'b0;
        exp_port.delete();
        exp_ofs.delete();
        exp_data.delete();
        @(negedge clk_emif);
        assert (wr_overflow) else begin
            $display("ERR wr_overflow got %h expected %h", wr_overflow, 1'b1);
            value_errs++;
        end

        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_emif);
        $display("Timeout after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== emif_wr_top.f ====
hw/emif_pkg.sv
hw/emif_bus_capture.sv
hw/type2_wr_decode.sv
hw/port_wr_buffer.sv
hw/port_wr_drain.sv
hw/emif_wr_top.sv
sim/tb_emif_wr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the EMIF write path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f emif_wr_top.f \
    --top-module tb_emif_wr_top -o tb_emif_wr_top

sim_out=$(./obj_dir/tb_emif_wr_top)
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
